/* common/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// width of a data word and of an instruction word
`define CPU_DATA_W 16

// architectural registers r0 to r7, where r7 doubles as the link register
`define CPU_REG_N 8

// words in the data memory, addressed by the low bits of the effective address
`define CPU_DMEM_DEPTH 16

`endif

/* common/isa_pkg.sv */
`include "cpu_config.svh"

package isa_pkg;

  typedef logic [`CPU_DATA_W-1:0]        word_t;     // data or instruction word
  typedef logic [$clog2(`CPU_REG_N)-1:0] reg_idx_t;  // register file index

  // only the kept subset of the opcode map is listed
  typedef enum logic [4:0] {
    op_nop   = 5'b00001,
    op_jal   = 5'b00110,
    op_st    = 5'b10000,
    op_ld    = 5'b10001,
    op_slbi  = 5'b10010,
    op_lbi   = 5'b11000,
    op_rtype = 5'b11011
  } opcode_t;

  // r-type function in the two low bits, sub is rs minus rt and andn is rs and not rt
  typedef enum logic [1:0] {
    fn_add  = 2'b00,
    fn_sub  = 2'b01,
    fn_xor  = 2'b10,
    fn_andn = 2'b11
  } func_t;

  localparam reg_idx_t link_reg = reg_idx_t'(`CPU_REG_N - 1);  // jal writes here

  localparam int op_msb   = 15;
  localparam int op_lsb   = 11;
  localparam int rs_msb   = 10;
  localparam int rs_lsb   = 8;
  localparam int rt_msb   = 7;  // also rd of the i-format
  localparam int rt_lsb   = 5;
  localparam int rdr_msb  = 4;  // rd of the r-format
  localparam int rdr_lsb  = 2;
  localparam int imm8_msb = 7;  // lbi and slbi immediate
  localparam int imm5_msb = 4;  // ld and st offset
  localparam int func_msb = 1;
  localparam int func_lsb = 0;

  function automatic opcode_t op_of(input word_t i);
    return opcode_t'(i[op_msb:op_lsb]);
  endfunction

  function automatic reg_idx_t rs_of(input word_t i);
    return i[rs_msb:rs_lsb];
  endfunction

  function automatic reg_idx_t rt_of(input word_t i);
    return i[rt_msb:rt_lsb];
  endfunction

  // rd sits in a different place for the r-format than for the i-format
  function automatic reg_idx_t rd_of(input word_t i);
    return (op_of(i) == op_rtype) ? i[rdr_msb:rdr_lsb] : i[rt_msb:rt_lsb];
  endfunction

  function automatic func_t func_of(input word_t i);
    return func_t'(i[func_msb:func_lsb]);
  endfunction

  // true for every opcode that ends in a register file write
  function automatic logic writes_reg(input opcode_t op);
    return op inside {op_rtype, op_lbi, op_slbi, op_ld, op_jal};
  endfunction

endpackage

/* common/pipe_pkg.sv */
`include "cpu_config.svh"

package pipe_pkg;

  // data memory word address taken from the low bits of rs plus offset
  typedef logic [$clog2(`CPU_DMEM_DEPTH)-1:0] dmem_addr_t;

  // where a decoded operand is taken from
  typedef enum logic [1:0] {
    fwd_none,        // register file value, which already covers distance three
    fwd_ex,          // result of the instruction one ahead
    fwd_mem_load,    // load data of the instruction two ahead
    fwd_mem_result   // alu or link result of the instruction two ahead
  } fwd_src_t;

  // what the memory stage does with the instruction it holds this cycle
  typedef enum logic [1:0] {
    stage_idle,   // bubble
    stage_alu,    // result passes through to writeback
    stage_load,   // data memory read feeds writeback
    stage_store   // data memory write at the end of the cycle
  } stage_state_t;

endpackage

/* common/stage_if.sv */
`timescale 1ns/1ns

// one pipeline stage as seen by the forwarding logic and by the stage behind it
interface stage_if (
  input logic clk  // sampling clock for checks on the consumer side
);
  import isa_pkg::*;

  logic     valid;       // low for a bubble
  word_t    instr;
  reg_idx_t dest;        // rd, rs or r7 already picked by the producer
  logic     reg_write;
  logic     mem_read;    // the instruction is a load
  word_t    result;      // alu result or effective address, the link value for jal
  word_t    pc_link;     // pc plus two of this instruction
  word_t    store_data;  // rd value of a store

  modport producer (
    output valid,
    output instr,
    output dest,
    output reg_write,
    output mem_read,
    output result,
    output pc_link,
    output store_data
  );

  modport consumer (
    input clk,
    input valid,
    input instr,
    input dest,
    input reg_write,
    input mem_read,
    input result,
    input pc_link,
    input store_data
  );

endinterface

/* forward/forward_unit.sv */
`timescale 1ns/1ns

module forward_unit (
  input  isa_pkg::word_t dec_instr,      // instruction being decoded, a nop in idle cycles
  input  isa_pkg::word_t rf_rs,
  input  isa_pkg::word_t rf_rt,
  input  isa_pkg::word_t rf_rd,
  stage_if.consumer      ex,
  stage_if.consumer      mem,
  input  isa_pkg::word_t mem_load_data,
  output isa_pkg::word_t opnd_rs,
  output isa_pkg::word_t opnd_rt,
  output isa_pkg::word_t opnd_rd
);
  import isa_pkg::*;
  import pipe_pkg::*;

  opcode_t  dec_op;
  reg_idx_t dec_rs;
  reg_idx_t dec_rt;
  reg_idx_t dec_rd;
  logic     use_rs;
  logic     use_rt;
  logic     use_rd;
  logic     ex_writes;
  logic     mem_writes;
  word_t    ex_value;
  word_t    mem_value;
  fwd_src_t src_rs;
  fwd_src_t src_rt;
  fwd_src_t src_rd;

  // execute is checked first so the youngest writer of a register wins
  function automatic fwd_src_t fwd_select(
    input logic     used,
    input reg_idx_t idx,
    input logic     ex_hit_en,
    input reg_idx_t ex_dest,
    input logic     mem_hit_en,
    input reg_idx_t mem_dest,
    input logic     mem_is_load
  );
    fwd_src_t src;
    src = fwd_none;
    if (used && ex_hit_en && (ex_dest == idx)) begin
      src = fwd_ex;
    end else if (used && mem_hit_en && (mem_dest == idx)) begin
      src = mem_is_load ? fwd_mem_load : fwd_mem_result;
    end
    return src;
  endfunction

  function automatic word_t fwd_mux(
    input fwd_src_t src,
    input word_t    rf_val,
    input word_t    ex_val,
    input word_t    ld_val,
    input word_t    mem_val
  );
    word_t val;
    case (src)
      fwd_ex:         val = ex_val;
      fwd_mem_load:   val = ld_val;
      fwd_mem_result: val = mem_val;
      default:        val = rf_val;
    endcase
    return val;
  endfunction

  assign dec_op = op_of(dec_instr);
  assign dec_rs = rs_of(dec_instr);
  assign dec_rt = rt_of(dec_instr);
  assign dec_rd = rd_of(dec_instr);  // only st reads it, so this is the i-format field

  // a field is forwarded only when the decoded instruction really reads it
  assign use_rs = dec_op inside {op_rtype, op_slbi, op_ld, op_st};  // slbi shifts its own rs
  assign use_rt = (dec_op == op_rtype);
  assign use_rd = (dec_op == op_st);  // store data

  // bubbles carry stale fields and must never match
  assign ex_writes  = ex.valid && ex.reg_write;
  assign mem_writes = mem.valid && mem.reg_write;

  // a jal in flight hands out its link value rather than an alu result
  assign ex_value  = (op_of(ex.instr) == op_jal) ? ex.pc_link : ex.result;
  assign mem_value = (op_of(mem.instr) == op_jal) ? mem.pc_link : mem.result;

  assign src_rs = fwd_select(use_rs, dec_rs, ex_writes, ex.dest,
                             mem_writes, mem.dest, mem.mem_read);
  assign src_rt = fwd_select(use_rt, dec_rt, ex_writes, ex.dest,
                             mem_writes, mem.dest, mem.mem_read);
  assign src_rd = fwd_select(use_rd, dec_rd, ex_writes, ex.dest,
                             mem_writes, mem.dest, mem.mem_read);

  assign opnd_rs = fwd_mux(src_rs, rf_rs, ex_value, mem_load_data, mem_value);
  assign opnd_rt = fwd_mux(src_rt, rf_rt, ex_value, mem_load_data, mem_value);
  assign opnd_rd = fwd_mux(src_rd, rf_rd, ex_value, mem_load_data, mem_value);

  // a forward from execute always points at a live instruction in that stage
  fwd_ex_live: assert property (@(posedge ex.clk)
    ((src_rs == fwd_ex) || (src_rt == fwd_ex) || (src_rd == fwd_ex)) |-> ex.valid);

  fwd_mem_live: assert property (@(posedge ex.clk)
    ((src_rs inside {fwd_mem_load, fwd_mem_result}) ||
     (src_rt inside {fwd_mem_load, fwd_mem_result}) ||
     (src_rd inside {fwd_mem_load, fwd_mem_result})) |-> mem.valid);

  // load data is not there yet one instruction behind a ld, the stimulus keeps this apart
  no_load_use: assert property (@(posedge ex.clk)
    (ex.valid && ex.mem_read) |->
      !((use_rs && (dec_rs == ex.dest)) ||
        (use_rt && (dec_rt == ex.dest)) ||
        (use_rd && (dec_rd == ex.dest))));

endmodule

/* source/decode_stage.sv */
`timescale 1ns/1ns

`include "cpu_config.svh"

module decode_stage (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             instr_valid,
  input  isa_pkg::word_t   instr,
  input  logic             wb_en,
  input  isa_pkg::reg_idx_t wb_dest,
  input  isa_pkg::word_t   wb_data,
  stage_if.consumer        ex,
  stage_if.consumer        mem,
  input  isa_pkg::word_t   mem_load_data,
  output logic             dec_valid,
  output isa_pkg::word_t   dec_instr,
  output isa_pkg::word_t   dec_pc,
  output isa_pkg::word_t   dec_rs_val,
  output isa_pkg::word_t   dec_rt_val,
  output isa_pkg::word_t   dec_rd_val
);
  import isa_pkg::*;

  localparam word_t nop_word = word_t'(op_nop) << op_lsb;

  word_t    regs [`CPU_REG_N];
  word_t    pc_q;      // pc of the next instruction to arrive
  word_t    fwd_instr;
  reg_idx_t rs_idx;
  reg_idx_t rt_idx;
  reg_idx_t rd_idx;
  word_t    rf_rs;
  word_t    rf_rt;
  word_t    rf_rd;
  word_t    opnd_rs;
  word_t    opnd_rt;
  word_t    opnd_rd;

  assign fwd_instr = instr_valid ? instr : nop_word;  // idle cycles read nothing
  assign rs_idx    = rs_of(fwd_instr);
  assign rt_idx    = rt_of(fwd_instr);
  assign rd_idx    = rd_of(fwd_instr);

  // write before read so a writeback in this cycle is seen at distance three
  assign rf_rs = (wb_en && (wb_dest == rs_idx)) ? wb_data : regs[rs_idx];
  assign rf_rt = (wb_en && (wb_dest == rt_idx)) ? wb_data : regs[rt_idx];
  assign rf_rd = (wb_en && (wb_dest == rd_idx)) ? wb_data : regs[rd_idx];

  forward_unit u_forward_unit (
    .dec_instr     (fwd_instr),
    .rf_rs         (rf_rs),
    .rf_rt         (rf_rt),
    .rf_rd         (rf_rd),
    .ex            (ex),
    .mem           (mem),
    .mem_load_data (mem_load_data),
    .opnd_rs       (opnd_rs),
    .opnd_rt       (opnd_rt),
    .opnd_rd       (opnd_rd)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `CPU_REG_N; i++) begin
        regs[i] <= '0;  // architectural state starts out cleared
      end
    end else if (wb_en) begin
      regs[wb_dest] <= wb_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
      pc_q      <= '0;
    end else begin
      dec_valid <= instr_valid;  // a missing strobe becomes a bubble
      if (instr_valid) begin
        pc_q <= pc_q + word_t'(2);
      end
    end
  end

  // operands are captured together with the instruction at its strobe edge
  always_ff @(posedge clk) begin
    if (instr_valid) begin
      dec_instr  <= instr;
      dec_pc     <= pc_q;
      dec_rs_val <= opnd_rs;
      dec_rt_val <= opnd_rt;
      dec_rd_val <= opnd_rd;
    end
  end

endmodule

/* source/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           dec_valid,
  input  isa_pkg::word_t dec_instr,
  input  isa_pkg::word_t dec_pc,
  input  isa_pkg::word_t dec_rs_val,
  input  isa_pkg::word_t dec_rt_val,
  input  isa_pkg::word_t dec_rd_val,
  stage_if.producer      ex
);
  import isa_pkg::*;

  opcode_t  op;
  func_t    fn;
  word_t    imm8_sext;
  word_t    imm5_zext;
  word_t    link;
  word_t    alu_out;
  reg_idx_t dest;

  assign op        = op_of(dec_instr);
  assign fn        = func_of(dec_instr);
  assign imm8_sext = word_t'($signed(dec_instr[imm8_msb:0]));
  assign imm5_zext = word_t'(dec_instr[imm5_msb:0]);  // offsets are never negative
  assign link      = dec_pc + word_t'(2);

  always_comb begin
    case (op)
      op_rtype: begin
        case (fn)
          fn_add:  alu_out = dec_rs_val + dec_rt_val;
          fn_sub:  alu_out = dec_rs_val - dec_rt_val;
          fn_xor:  alu_out = dec_rs_val ^ dec_rt_val;
          default: alu_out = dec_rs_val & ~dec_rt_val;  // andn
        endcase
      end
      op_lbi:       alu_out = imm8_sext;
      op_slbi:      alu_out = (dec_rs_val << 8) | word_t'(dec_instr[imm8_msb:0]);
      op_ld, op_st: alu_out = dec_rs_val + imm5_zext;  // effective address
      op_jal:       alu_out = link;
      default:      alu_out = '0;
    endcase
  end

  // the three destination cases of the isa collapse into one index here
  always_comb begin
    case (op)
      op_rtype, op_ld: dest = rd_of(dec_instr);
      op_lbi, op_slbi: dest = rs_of(dec_instr);
      op_jal:          dest = link_reg;
      default:         dest = '0;
    endcase
  end

  // execute view for the forwarding unit and the memory stage register
  assign ex.valid      = dec_valid;
  assign ex.instr      = dec_instr;
  assign ex.dest       = dest;
  assign ex.reg_write  = writes_reg(op);
  assign ex.mem_read   = (op == op_ld);
  assign ex.result     = alu_out;
  assign ex.pc_link    = link;
  assign ex.store_data = dec_rd_val;  // already forwarded in decode

  // the first cycle out of reset holds a bubble in execute
  ex_empty_after_reset: assert property (@(posedge clk)
    (rst_n && $past(!rst_n)) |-> !ex.valid);

endmodule

/* source/memory_stage.sv */
`timescale 1ns/1ns

`include "cpu_config.svh"

module memory_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  stage_if.consumer            ex,
  stage_if.producer            mem,
  output isa_pkg::word_t       mem_load_data,
  output logic                 wb_en,
  output isa_pkg::reg_idx_t    wb_dest,
  output isa_pkg::word_t       wb_data,
  output logic                 st_valid,
  output pipe_pkg::dmem_addr_t st_addr,
  output isa_pkg::word_t       st_data
);
  import isa_pkg::*;
  import pipe_pkg::*;

  word_t        dmem [`CPU_DMEM_DEPTH];
  dmem_addr_t   addr;
  stage_state_t mem_state;

  assign addr          = dmem_addr_t'(mem.result);  // upper address bits are ignored
  assign mem_load_data = dmem[addr];                // read during the memory cycle

  always_comb begin
    if (!mem.valid) begin
      mem_state = stage_idle;
    end else if (mem.mem_read) begin
      mem_state = stage_load;
    end else if (op_of(mem.instr) == op_st) begin
      mem_state = stage_store;
    end else begin
      mem_state = stage_alu;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem.valid <= 1'b0;
    end else begin
      mem.valid <= ex.valid;
    end
  end

  always_ff @(posedge clk) begin
    mem.instr      <= ex.instr;
    mem.dest       <= ex.dest;
    mem.reg_write  <= ex.reg_write;
    mem.mem_read   <= ex.mem_read;
    mem.result     <= ex.result;
    mem.pc_link    <= ex.pc_link;
    mem.store_data <= ex.store_data;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `CPU_DMEM_DEPTH; i++) begin
        dmem[i] <= '0;
      end
    end else if (mem_state == stage_store) begin
      dmem[addr] <= mem.store_data;
    end
  end

  // writeback and store report both come out one cycle after the memory cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_en    <= 1'b0;
      st_valid <= 1'b0;
    end else begin
      wb_en    <= mem.valid && mem.reg_write;
      st_valid <= (mem_state == stage_store);
    end
  end

  always_ff @(posedge clk) begin
    wb_dest <= mem.dest;
    wb_data <= (mem_state == stage_load) ? mem_load_data : mem.result;
    st_addr <= addr;
    st_data <= mem.store_data;
  end

  // every register write traces back to a writing opcode one cycle earlier
  wb_from_writer: assert property (@(posedge clk) disable iff (!rst_n)
    wb_en |-> $past(mem.valid && writes_reg(op_of(mem.instr))));

endmodule

/* source/bypass_core_top.sv */
`timescale 1ns/1ns

module bypass_core_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 instr_valid,
  input  isa_pkg::word_t       instr,
  output logic                 wb_valid,
  output isa_pkg::reg_idx_t    wb_dest,
  output isa_pkg::word_t       wb_data,
  output logic                 st_valid,
  output pipe_pkg::dmem_addr_t st_addr,
  output isa_pkg::word_t       st_data
);
  import isa_pkg::*;

  logic  dec_valid;
  word_t dec_instr;
  word_t dec_pc;
  word_t dec_rs_val;
  word_t dec_rt_val;
  word_t dec_rd_val;
  word_t mem_load_data;

  stage_if ex_if  (.clk(clk));  // instruction in execute
  stage_if mem_if (.clk(clk));  // instruction in memory

  // the writeback ports double as the register file write port
  decode_stage u_decode_stage (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid   (instr_valid),
    .instr         (instr),
    .wb_en         (wb_valid),
    .wb_dest       (wb_dest),
    .wb_data       (wb_data),
    .ex            (ex_if.consumer),
    .mem           (mem_if.consumer),
    .mem_load_data (mem_load_data),
    .dec_valid     (dec_valid),
    .dec_instr     (dec_instr),
    .dec_pc        (dec_pc),
    .dec_rs_val    (dec_rs_val),
    .dec_rt_val    (dec_rt_val),
    .dec_rd_val    (dec_rd_val)
  );

  execute_stage u_execute_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .dec_valid  (dec_valid),
    .dec_instr  (dec_instr),
    .dec_pc     (dec_pc),
    .dec_rs_val (dec_rs_val),
    .dec_rt_val (dec_rt_val),
    .dec_rd_val (dec_rd_val),
    .ex         (ex_if.producer)
  );

  memory_stage u_memory_stage (
    .clk           (clk),
    .rst_n         (rst_n),
    .ex            (ex_if.consumer),
    .mem           (mem_if.producer),
    .mem_load_data (mem_load_data),
    .wb_en         (wb_valid),
    .wb_dest       (wb_dest),
    .wb_data       (wb_data),
    .st_valid      (st_valid),
    .st_addr       (st_addr),
    .st_data       (st_data)
  );

endmodule

/* tests/isa_ref_model.svh */
`ifndef ISA_REF_MODEL_SVH
`define ISA_REF_MODEL_SVH

// architectural state, advanced one whole instruction at a time with no notion of a pipeline
word_t ref_regs [8];
word_t ref_dmem [16];
word_t ref_pc;

// expected writebacks hold {dest, data} and expected stores hold {addr, data}
logic [18:0] wb_exp_q [$];
logic [19:0] st_exp_q [$];
int          wb_due_q [$];  // clock edge at which each writeback has to show up
int          st_due_q [$];

task automatic reset_model();
  for (int i = 0; i < 8; i++) begin
    ref_regs[i] = '0;
  end
  for (int i = 0; i < 16; i++) begin
    ref_dmem[i] = '0;  // data memory comes out of reset cleared
  end
  ref_pc = '0;
endtask

task automatic record_write(input reg_idx_t dest, input word_t data, input int due);
  ref_regs[dest] = data;
  wb_exp_q.push_back({dest, data});
  wb_due_q.push_back(due);
endtask

// executes one instruction on the model and queues what the pipe must report for it
task automatic apply_instr(input word_t ins, input int due);
  opcode_t  op;
  reg_idx_t rs;
  reg_idx_t rt;
  reg_idx_t rd;
  word_t    a;
  word_t    b;
  word_t    ea;
  op = opcode_t'(ins[15:11]);
  rs = ins[10:8];
  rt = ins[7:5];                   // the i-format rd of ld and st sits here too
  rd = ins[4:2];                   // r-format destination
  a  = ref_regs[rs];
  b  = ref_regs[rt];
  ea = a + {11'd0, ins[4:0]};      // offset is zero extended
  case (op)
    op_rtype: begin
      case (ins[1:0])
        2'b00:   record_write(rd, a + b, due);
        2'b01:   record_write(rd, a - b, due);
        2'b10:   record_write(rd, a ^ b, due);
        default: record_write(rd, a & ~b, due);  // andn clears the bits set in rt
      endcase
    end
    op_lbi:  record_write(rs, {{8{ins[7]}}, ins[7:0]}, due);
    op_slbi: record_write(rs, {a[7:0], ins[7:0]}, due);  // old low byte moves up
    op_ld:   record_write(rt, ref_dmem[ea[3:0]], due);
    op_st: begin
      ref_dmem[ea[3:0]] = b;
      st_exp_q.push_back({ea[3:0], b});
      st_due_q.push_back(due);
    end
    op_jal:  record_write(3'd7, ref_pc + 16'd2, due);  // link only, fetch is not redirected
    default: ;
  endcase
  ref_pc = ref_pc + 16'd2;
endtask

`endif

/* tests/tb_bypass_core.sv */
`timescale 1ns/1ns

module tb_bypass_core;
  import isa_pkg::*;
  import pipe_pkg::*;

  localparam int n_instr   = 2000;
  localparam int idle_pct  = 30;
  localparam int drain_max = 50;  // edges allowed for the last results to come out

  logic       clk = 1'b0;
  logic       rst_n;
  logic       instr_valid;
  word_t      instr;
  logic       wb_valid;
  reg_idx_t   wb_dest;
  word_t      wb_data;
  logic       st_valid;
  dmem_addr_t st_addr;
  word_t      st_data;

  int edge_cnt   = 0;  // number of rising edges seen so far
  int mismatches = 0;
  int other_errs = 0;
  int wb_seen    = 0;
  int st_seen    = 0;

  `include "isa_ref_model.svh"

  bypass_core_top u_bypass_core_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb_valid    (wb_valid),
    .wb_dest     (wb_dest),
    .wb_data     (wb_data),
    .st_valid    (st_valid),
    .st_addr     (st_addr),
    .st_data     (st_data)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    edge_cnt <= edge_cnt + 1;
  end

  // most picks land on r1 to r3 or on r7 so that hazards come up all the time
  function automatic reg_idx_t pick_reg();
    int r;
    r = $urandom_range(0, 9);
    if (r < 6) begin
      return 3'(r % 3 + 1);
    end else if (r < 8) begin
      return 3'd7;  // link register, shared between jal and r-type writers
    end
    return 3'($urandom_range(0, 7));
  endfunction

  function automatic word_t make_instr();
    int       pick;
    reg_idx_t a;
    reg_idx_t b;
    reg_idx_t c;
    word_t    ins;
    pick = $urandom_range(0, 99);
    a    = pick_reg();
    b    = pick_reg();
    c    = pick_reg();
    if (pick < 34) begin
      ins = {op_rtype, a, b, c, 2'($urandom_range(0, 3))};
    end else if (pick < 46) begin
      ins = {op_lbi, a, 8'($urandom)};
    end else if (pick < 58) begin
      ins = {op_slbi, a, 8'($urandom)};
    end else if (pick < 70) begin
      ins = {op_ld, a, b, 5'($urandom)};
    end else if (pick < 82) begin
      ins = {op_st, a, b, 5'($urandom)};
    end else if (pick < 91) begin
      ins = {op_jal, 11'($urandom)};
    end else begin
      ins = {op_nop, 11'($urandom)};  // junk fields that nothing may read
    end
    return ins;
  endfunction

  // true when the instruction takes register r as a source
  function automatic logic reads_reg(input word_t ins, input reg_idx_t r);
    opcode_t op;
    op = opcode_t'(ins[15:11]);
    case (op)
      op_rtype, op_st: return (ins[10:8] == r) || (ins[7:5] == r);  // st reads its data reg
      op_slbi, op_ld:  return ins[10:8] == r;
      default:         return 1'b0;
    endcase
  endfunction

  task automatic expect_eq(input string name, input word_t got, input word_t exp);
    assert (got == exp) else begin
      mismatches++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic expect_on_time(input string what, input int due);
    assert (edge_cnt == due) else begin
      other_errs++;
      $display("%s arrived after edge %0d but was due after edge %0d", what, edge_cnt, due);
    end
  endtask

  // outputs are registered, so the falling edge sees them settled
  always @(negedge clk) begin
    logic [18:0] wb_rec;
    logic [19:0] st_rec;
    if (rst_n && wb_valid) begin
      wb_seen++;
      assert (wb_exp_q.size() != 0) else begin
        other_errs++;
        $display("writeback after edge %0d with no instruction outstanding", edge_cnt);
      end
      if (wb_exp_q.size() != 0) begin
        wb_rec = wb_exp_q.pop_front();
        expect_on_time("writeback", wb_due_q.pop_front());
        expect_eq("wb_dest", word_t'(wb_dest), word_t'(wb_rec[18:16]));
        expect_eq("wb_data", wb_data, wb_rec[15:0]);
      end
    end
    if (rst_n && st_valid) begin
      st_seen++;
      assert (st_exp_q.size() != 0) else begin
        other_errs++;
        $display("store after edge %0d with no store outstanding", edge_cnt);
      end
      if (st_exp_q.size() != 0) begin
        st_rec = st_exp_q.pop_front();
        expect_on_time("store", st_due_q.pop_front());
        expect_eq("st_addr", word_t'(st_addr), word_t'(st_rec[19:16]));
        expect_eq("st_data", st_data, st_rec[15:0]);
      end
    end
  end

  initial begin
    word_t    ins;
    reg_idx_t ld_dest;
    logic     after_ld;
    int       issued;
    int       cycles;
    int       tries;
    int       waited;
    void'($urandom(23773));
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    after_ld    = 1'b0;
    ld_dest     = '0;
    issued      = 0;
    cycles      = 0;
    reset_model();
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    repeat (6) @(posedge clk);  // quiet stretch, nothing may leave the pipe before a strobe
    while (issued < n_instr && cycles < 20 * n_instr) begin
      @(posedge clk);
      cycles++;
      if ($urandom_range(0, 99) < idle_pct) begin
        instr_valid <= 1'b0;
        instr       <= word_t'($urandom);  // garbage on a bubble cycle
      end else begin
        ins   = make_instr();
        tries = 0;
        // load data only reaches decode two instructions behind the ld
        while (after_ld && reads_reg(ins, ld_dest) && tries < 50) begin
          ins = make_instr();
          tries++;
        end
        if (after_ld && reads_reg(ins, ld_dest)) begin
          ins = {op_nop, 11'd0};
        end
        instr_valid <= 1'b1;
        instr       <= ins;
        apply_instr(ins, edge_cnt + 4);  // strobe sampled one edge later, result three after that
        after_ld = (ins[15:11] == op_ld);
        ld_dest  = ins[7:5];
        issued++;
      end
    end
    assert (issued == n_instr) else begin
      other_errs++;
      $display("stimulus loop ran out of cycles after %0d instructions", issued);
    end
    @(posedge clk);
    instr_valid <= 1'b0;
    waited = 0;
    while ((wb_exp_q.size() != 0 || st_exp_q.size() != 0) && waited < drain_max) begin
      @(posedge clk);
      waited++;
    end
    assert (wb_exp_q.size() == 0 && st_exp_q.size() == 0) else begin
      other_errs++;
      $display("pipeline did not drain, %0d writebacks and %0d stores still missing",
               wb_exp_q.size(), st_exp_q.size());
    end
    repeat (4) @(posedge clk);  // a stray result after the drain would still be caught
    $display("instructions %0d writebacks %0d stores %0d mismatches %0d other errors %0d",
             issued, wb_seen, st_seen, mismatches, other_errs);
    if (mismatches == 0 && other_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+common
+incdir+tests
common/isa_pkg.sv
common/pipe_pkg.sv
common/stage_if.sv
forward/forward_unit.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/bypass_core_top.sv
tests/tb_bypass_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with verilator, runs it and scans the log for the fail message

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_bypass_core -f flist.f -o tb_bypass_core_sim \
  || { echo "verilator build failed"; exit 1; }

./obj_dir/tb_bypass_core_sim > "$log" 2>&1 \
  || { cat "$log"; echo "simulation ended abnormally"; exit 1; }

cat "$log"
grep -q ">>> FAIL" "$log" && { echo "testbench reported failure"; exit 1; }
echo "simulation passed"
exit 0
